// File: pdm_pkg.sv
package pdm_pkg;

    // CIC accumulator width, the integrators wrap modulo 2^cic_width
    localparam int cic_width = 32;
    localparam int pcm_width = 16;          // signed audio sample
    localparam int cic_order = 5;

    // legal decimation range, 64^5 still fits in 31 bits
    localparam int decim_factor_min = 2;
    localparam int decim_factor_max = 64;

    // PCM words dropped after each start while the filter settles
    localparam int settle_samples = 2;

    typedef logic [6:0] decim_factor_t;
    typedef logic [7:0] clk_div_t;          // half period of the bit clock minus one
    typedef logic [4:0] shift_t;            // right shift applied by the scaler

    typedef enum logic [1:0] {
        capture_idle   = 2'd0,
        capture_clear  = 2'd1,
        capture_settle = 2'd2,
        capture_run    = 2'd3
    } capture_state_t;

endpackage

// File: pdm_clock_gen.sv
module pdm_clock_gen
    import pdm_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     clock_en_i,
    input  clk_div_t clk_div_i,
    output logic     pdm_clk_o,
    output logic     sample_stb_o
);

    clk_div_t count_q;
    logic     armed_q;      // set once the counter holds a live value
    clk_div_t count_cur;
    logic     toggle;

    // on the first enabled cycle the counter behaves as if it was just reloaded,
    // so the first toggle comes clk_div_i+1 cycles after the enable rises
    assign count_cur = armed_q ? count_q : clk_div_i;
    assign toggle    = (count_cur == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !clock_en_i) begin
            count_q      <= '0;
            armed_q      <= 1'b0;
            pdm_clk_o    <= 1'b0;
            sample_stb_o <= 1'b0;
        end else begin
            armed_q      <= 1'b1;
            sample_stb_o <= 1'b0;
            if (toggle) begin
                count_q   <= clk_div_i;
                pdm_clk_o <= ~pdm_clk_o;
                // one strobe per bit period, raised together with the bit clock
                sample_stb_o <= ~pdm_clk_o;
            end else begin
                count_q <= count_cur - 1'b1;
            end
        end
    end

endmodule

// File: pdm_capture_ctrl.sv
module pdm_capture_ctrl
    import pdm_pkg::*;
#(
    parameter int settle_samples = pdm_pkg::settle_samples
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic stop_i,
    input  logic scaled_valid_i,
    output logic clock_en_o,
    output logic filter_clear_o,
    output logic pcm_valid_o,
    output logic busy_o
);

    localparam int settle_w = (settle_samples > 0) ? $clog2(settle_samples + 1) : 1;

    capture_state_t      state_q;
    capture_state_t      state_d;
    logic [settle_w-1:0] settle_cnt_q;   // words seen since entering settle
    logic                settle_done;

    assign settle_done = (settle_cnt_q == settle_w'(settle_samples));

    always_comb begin
        state_d = state_q;
        case (state_q)
            capture_idle: begin
                if (start_i) begin
                    state_d = capture_clear;
                end
            end
            capture_clear: begin
                state_d = capture_settle;    // clear lasts exactly one cycle
            end
            capture_settle: begin
                if (settle_done) begin
                    state_d = capture_run;
                end
            end
            default: begin
                state_d = state_q;
            end
        endcase
        if (start_i) begin
            state_d = capture_clear;         // a start while capturing restarts the filter
        end
        if (stop_i) begin
            state_d = capture_idle;          // stop wins over everything
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= capture_idle;
            settle_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q != capture_settle) begin
                settle_cnt_q <= '0;
            end else if (scaled_valid_i && !settle_done) begin
                settle_cnt_q <= settle_cnt_q + 1'b1;
            end
        end
    end

    // the bit clock runs through clear and settle so the filter fills up
    assign clock_en_o     = (state_q != capture_idle);
    assign busy_o         = (state_q != capture_idle);
    assign filter_clear_o = (state_q == capture_clear);
    assign pcm_valid_o    = scaled_valid_i && (state_q == capture_run);

endmodule

// File: pdm2pcm_decimator.sv
module pdm2pcm_decimator
    import pdm_pkg::*;
#(
    parameter int width        = cic_width,
    parameter int filter_order = cic_order,
    parameter int comb_delay   = 1
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             reset_filter_i,
    input  decim_factor_t    decimator_factor_i,
    input  logic             pdm_i,
    input  logic             valid_i,
    output logic [width-1:0] pcm_o,
    output logic             valid_o
);

    decim_factor_t decim_cnt_q;
    logic          decim_stb_q;     // high the cycle after every factor-th strobe

    // integrator state, stage 0 accumulates the raw PDM bits
    logic [filter_order-1:0][width-1:0] integ_q;

    // comb pipeline and its differential delay lines
    logic [filter_order-1:0][width-1:0]                 comb_in;
    logic [filter_order-1:0][width-1:0]                 comb_q;
    logic [filter_order-1:0][comb_delay-1:0][width-1:0] comb_dly_q;

    // a one enters per decimated sample, the top bit marks a full comb pipeline
    logic [filter_order-1:0] fill_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || reset_filter_i) begin
            decim_cnt_q <= '0;
            decim_stb_q <= 1'b0;
        end else begin
            decim_stb_q <= 1'b0;
            if (valid_i) begin
                if (decim_cnt_q == decimator_factor_i - 1'b1) begin
                    decim_cnt_q <= '0;
                    decim_stb_q <= 1'b1;
                end else begin
                    decim_cnt_q <= decim_cnt_q + 1'b1;
                end
            end
        end
    end

    // integrators run at the strobe rate and are pipelined stage to stage,
    // the extra delay only shifts the decimation phase
    always_ff @(posedge clk_i) begin
        if (reset_filter_i) begin
            integ_q <= '0;
        end else if (valid_i) begin
            integ_q[0] <= integ_q[0] + width'(pdm_i);
            for (int i = 1; i < filter_order; i++) begin
                integ_q[i] <= integ_q[i] + integ_q[i-1];
            end
        end
    end

    always_comb begin
        comb_in[0] = integ_q[filter_order-1];   // already holds the last strobe of the window
        for (int i = 1; i < filter_order; i++) begin
            comb_in[i] = comb_q[i-1];
        end
    end

    // combs only move on decimated samples, wrap-around in the integrators
    // cancels here as long as the true result fits in width bits
    always_ff @(posedge clk_i) begin
        if (reset_filter_i) begin
            comb_q     <= '0;
            comb_dly_q <= '0;
        end else if (decim_stb_q) begin
            for (int i = 0; i < filter_order; i++) begin
                comb_q[i]        <= comb_in[i] - comb_dly_q[i][comb_delay-1];
                comb_dly_q[i][0] <= comb_in[i];
                for (int j = 1; j < comb_delay; j++) begin
                    comb_dly_q[i][j] <= comb_dly_q[i][j-1];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || reset_filter_i) begin
            fill_q  <= '0;
            valid_o <= 1'b0;
        end else begin
            // the first filter_order decimated samples after a clear are dropped
            valid_o <= decim_stb_q && fill_q[filter_order-1];
            if (decim_stb_q) begin
                fill_q <= (fill_q << 1) | filter_order'(1);
            end
        end
    end

    assign pcm_o = comb_q[filter_order-1];

endmodule

// File: pcm_scaler.sv
module pcm_scaler
    import pdm_pkg::*;
#(
    parameter int in_width  = cic_width,
    parameter int out_width = pcm_width
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [in_width-1:0]         data_i,
    input  logic                        valid_i,
    input  shift_t                      shift_i,
    output logic signed [out_width-1:0] pcm_o,
    output logic                        valid_o
);

    // clamp limits of the signed output, held at the internal width
    localparam logic signed [in_width:0] sat_max =
        {{(in_width - out_width + 2){1'b0}}, {(out_width - 1){1'b1}}};
    localparam logic signed [in_width:0] sat_min =
        {{(in_width - out_width + 2){1'b1}}, {(out_width - 1){1'b0}}};

    logic [5:0]               offset_pos;
    logic signed [in_width:0] offset;
    logic signed [in_width:0] centered;
    logic signed [in_width:0] shifted;

    // the CIC result is unsigned with midscale at half of 2^(shift+out_width)
    assign offset_pos = {1'b0, shift_i} + 6'(out_width - 1);
    assign offset     = {{in_width{1'b0}}, 1'b1} << offset_pos;
    assign centered   = $signed({1'b0, data_i}) - offset;
    assign shifted    = centered >>> shift_i;

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            if (shifted > sat_max) begin
                pcm_o <= sat_max[out_width-1:0];
            end else if (shifted < sat_min) begin
                pcm_o <= sat_min[out_width-1:0];
            end else begin
                pcm_o <= shifted[out_width-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;     // sample lands exactly one cycle later
        end
    end

endmodule

// File: pdm_mic_top.sv
module pdm_mic_top
    import pdm_pkg::*;
#(
    parameter int filter_order   = cic_order,
    parameter int comb_delay     = 1,
    parameter int settle_samples = pdm_pkg::settle_samples
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    input  logic                        stop_i,
    input  clk_div_t                    clk_div_i,
    input  decim_factor_t               decim_factor_i,
    input  shift_t                      shift_i,
    input  logic                        pdm_data_i,
    output logic                        pdm_clk_o,
    output logic signed [pcm_width-1:0] pcm_o,
    output logic                        pcm_valid_o,
    output logic                        busy_o
);

    logic                 clock_en;
    logic                 filter_clear;
    logic                 sample_stb;
    logic [cic_width-1:0] cic_data;
    logic                 cic_valid;
    logic                 scaled_valid;   // every scaler word, before run gating

    pdm_clock_gen u_clock_gen (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clock_en_i   (clock_en),
        .clk_div_i    (clk_div_i),
        .pdm_clk_o    (pdm_clk_o),
        .sample_stb_o (sample_stb)
    );

    pdm_capture_ctrl #(
        .settle_samples (settle_samples)
    ) u_capture_ctrl (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .stop_i         (stop_i),
        .scaled_valid_i (scaled_valid),
        .clock_en_o     (clock_en),
        .filter_clear_o (filter_clear),
        .pcm_valid_o    (pcm_valid_o),
        .busy_o         (busy_o)
    );

    // the PDM bit is taken in the system clock domain on the sample strobe
    pdm2pcm_decimator #(
        .width        (cic_width),
        .filter_order (filter_order),
        .comb_delay   (comb_delay)
    ) u_decimator (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .reset_filter_i     (filter_clear),
        .decimator_factor_i (decim_factor_i),
        .pdm_i              (pdm_data_i),
        .valid_i            (sample_stb),
        .pcm_o              (cic_data),
        .valid_o            (cic_valid)
    );

    pcm_scaler #(
        .in_width  (cic_width),
        .out_width (pcm_width)
    ) u_scaler (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (cic_data),
        .valid_i (cic_valid),
        .shift_i (shift_i),
        .pcm_o   (pcm_o),
        .valid_o (scaled_valid)
    );

endmodule

// File: tb_pdm_mic.sv
module tb_pdm_mic
    import pdm_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // three dropped words plus the fill period cover the whole 5R-bit filter memory
    localparam int tb_settle = 3;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        start;
    logic                        stop;
    clk_div_t                    clk_div;
    decim_factor_t               decim_factor;
    shift_t                      shift;
    logic                        pdm_data;
    logic                        pdm_clk;
    logic signed [pcm_width-1:0] pcm;
    logic                        pcm_valid;
    logic                        busy;

    int          q_div[$];
    int          q_fac[$];
    int          q_shift[$];
    logic [31:0] q_pat[$];
    int          q_len[$];
    int          q_checks[$];
    int          q_exp[$];

    logic [31:0] pat_word = '0;     // repeating microphone pattern, LSB first
    int          pat_len = 1;
    int          pat_idx = 0;
    int          bits_sent = 0;     // rising bit clock edges since the last start
    int          last_toggle = -1;  // cycle of the last bit clock toggle, -1 while idle
    logic        pdm_clk_seen = 1'b0;
    int          cycles = 0;
    int          cycle_limit = 32'h7fff_ffff;
    integer      seed = 32'hb772_8807;

    pdm_mic_top #(
        .settle_samples (tb_settle)
    ) DUT (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .start_i        (start),
        .stop_i         (stop),
        .clk_div_i      (clk_div),
        .decim_factor_i (decim_factor),
        .shift_i        (shift),
        .pdm_data_i     (pdm_data),
        .pdm_clk_o      (pdm_clk),
        .pcm_o          (pcm),
        .pcm_valid_o    (pcm_valid),
        .busy_o         (busy)
    );

    always #20 clk = ~clk;

    // microphone model, a new bit follows every rising bit clock
    always @(posedge pdm_clk) begin
        #2;
        pdm_data  = pat_word[pat_idx];
        pat_idx   = (pat_idx + 1) % pat_len;
        bits_sent = bits_sent + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles without finishing the cases", cycles);
            abort_run();
        end
    end

    always @(negedge clk) begin
        if (pcm_valid && !busy) begin
            $display("pcm_valid_o was high while busy_o was low at %0t", $time);
            abort_run();
        end
    end

    // the bit clock toggles every clk_div+1 cycles, counted from the enable
    always @(negedge clk) begin
        if (busy !== 1'b1) begin
            last_toggle = -1;
        end else if (last_toggle < 0) begin
            last_toggle = cycles;
        end else if (pdm_clk !== pdm_clk_seen) begin
            check_cycles(cycles - last_toggle, int'(clk_div) + 1, "bit clock half period");
            last_toggle = cycles;
        end else if (cycles - last_toggle > int'(clk_div) + 1) begin
            $display("pdm_clk_o stopped toggling at %0t", $time);
            abort_run();
        end
        pdm_clk_seen = pdm_clk;
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_sample(input logic signed [pcm_width-1:0] got,
                                input logic signed [pcm_width-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s gave pcm_o %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s gave busy_o %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("[FAIL] %0t: %s was %0d cycles, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // steady CIC output is R^5 times the density of ones, then centered, shifted, clamped
    function automatic logic signed [pcm_width-1:0] rule_sample(input int factor,
            input int sh, input logic [31:0] pattern, input int len);
        longint f;
        longint ones;
        longint value;
        f    = factor;
        ones = 0;
        for (int i = 0; i < len; i++) begin
            ones += pattern[i];
        end
        value = f * f * f * f * f * ones / len;
        value = (value - (longint'(1) << (sh + 15))) >>> sh;
        if (value > 32767) begin
            value = 32767;
        end else if (value < -32768) begin
            value = -32768;
        end
        return pcm_width'(value);
    endfunction

    task automatic add_case(input int div, input int fac, input int sh, input logic [31:0] pat,
                            input int len, input int chk, input int exp_v);
        if (fac < decim_factor_min || fac > decim_factor_max || len < 1 || len > 32
                || fac % len != 0) begin
            $display("case with factor %0d and pattern length %0d is not usable", fac, len);
            abort_run();
        end
        q_div.push_back(div);
        q_fac.push_back(fac);
        q_shift.push_back(sh);
        q_pat.push_back(pat);
        q_len.push_back(len);
        q_checks.push_back(chk);
        q_exp.push_back(exp_v);
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        int          div, fac, sh, len, chk, exp_v;
        logic [31:0] pat;
        fd = $fopen("pdm_mic_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open pdm_mic_cases.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;   // blank line or column description
            end
            n = $sscanf(line, "%d %d %d %h %d %d %d", div, fac, sh, pat, len, chk, exp_v);
            if (n != 7) begin
                $display("malformed line in the case file: %s", line);
                abort_run();
            end
            add_case(div, fac, sh, pat, len, chk, exp_v);
            if (int'(rule_sample(fac, sh, pat, len)) != exp_v) begin
                $display("case file value %0d disagrees with the scaling rule", exp_v);
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_valid();
        do begin
            @(negedge clk);
        end while (!pcm_valid);
    endtask

    task automatic run_case(input int c);
        int period;
        int last_cycle;
        period = 2 * (q_div[c] + 1);    // system cycles per PDM bit
        step();
        clk_div      = clk_div_t'(q_div[c]);
        decim_factor = decim_factor_t'(q_fac[c]);
        shift        = shift_t'(q_shift[c]);
        pat_word     = q_pat[c];
        pat_len      = q_len[c];
        pat_idx      = 0;
        bits_sent    = 0;
        step();
        start = 1'b1;
        step();
        start = 1'b0;
        @(negedge clk);
        check_busy(busy, 1'b1, "start");
        wait_valid();
        // fill period and dropped words each take one whole decimation window of bits
        if (bits_sent < (tb_settle + cic_order + 1) * q_fac[c]
                || bits_sent >= (tb_settle + cic_order + 2) * q_fac[c]) begin
            $display("[FAIL] %0t: case %0d gave its first sample after %0d bits",
                     $time, c, bits_sent);
            abort_run();
        end
        for (int i = 0; i < q_checks[c]; i++) begin
            if (i > 0) begin
                wait_valid();
                check_cycles(cycles - last_cycle, q_fac[c] * period, "sample spacing");
            end
            last_cycle = cycles;
            check_sample(pcm, pcm_width'(q_exp[c]), $sformatf("case %0d word %0d", c, i));
        end
        step();
        stop = 1'b1;
        step();
        stop = 1'b0;
        @(negedge clk);
        check_busy(busy, 1'b0, "stop");
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        stop         = 1'b0;
        clk_div      = '0;
        decim_factor = decim_factor_t'(decim_factor_min);
        shift        = '0;
        pdm_data     = 1'b0;
        read_cases();
        // two extra cases with random 8-bit patterns at factor 32
        repeat (2) begin
            pat_word = $random(seed) & 32'hff;
            add_case(1, 32, 9, pat_word, 8, 3, int'(rule_sample(32, 9, pat_word, 8)));
        end
        cycle_limit = 400;
        foreach (q_fac[c]) begin
            cycle_limit += (tb_settle + cic_order + q_checks[c] + 2) * q_fac[c]
                           * 2 * (q_div[c] + 1) + 20;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_busy(busy, 1'b0, "reset");
        foreach (q_fac[c]) begin
            run_case(c);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: pdm_mic_cases.txt
# clk_div factor shift pattern(hex, LSB first) pattern_length checked_samples expected
# clk_div, factor, shift, length, checks and expected are decimal
1 64 14 1 1 4 32767
1 64 14 0 1 3 -32768
0 64 14 1 2 4 0
2 32 9 1 1 3 32767
0 32 9 0 1 3 -32768
1 32 9 3 4 3 0
3 16 4 1 4 4 -16384
0 8 0 7 4 3 -8192
1 48 12 1 3 3 -12032
2 40 11 7 4 3 4732
1 32 5 1 1 3 32767
0 32 5 0 1 3 -32768
5 16 4 7 4 3 16384
0 2 0 1 1 4 -32736
1 60 13 5 5 3 5200

// File: filelist.f
pdm_pkg.sv
pdm_clock_gen.sv
pdm_capture_ctrl.sv
pdm2pcm_decimator.sv
pcm_scaler.sv
pdm_mic_top.sv
tb_pdm_mic.sv

// File: Bender.yml
package:
  name: pdm_mic

sources:
  - files:
      - pdm_pkg.sv
      - pdm_clock_gen.sv
      - pdm_capture_ctrl.sv
      - pdm2pcm_decimator.sv
      - pcm_scaler.sv
      - pdm_mic_top.sv
  - target: test
    files:
      - tb_pdm_mic.sv
